/* include/debugRegNo.svh */
// Register numbers for abstract register access: CSRs, GPRs, FPRs and scan-chain fields
`ifndef DEBUG_REG_NO_SVH
`define DEBUG_REG_NO_SVH

// Floating-point CSRs
`define FFLAGS_REGNO        16'h0001
`define FRM_REGNO           16'h0002
`define FCSR_REGNO          16'h0003

// Supervisor CSRs
`define SSTATUS_REGNO       16'h0100
`define SIE_REGNO           16'h0104
`define STVEC_REGNO         16'h0105
`define SCOUNTEREN_REGNO    16'h0106
`define SSCRATCH_REGNO      16'h0140
`define SIP_REGNO           16'h0144
`define SATP_REGNO          16'h0180

// Machine trap setup and handling
`define MSTATUS_REGNO       16'h0300
`define MCOUNTEREN_REGNO    16'h0306
`define MSCRATCH_REGNO      16'h0340
`define MIP_REGNO           16'h0344

// Debug mode CSRs
`define DCSR_REGNO          16'h07B0
`define DPC_REGNO           16'h07B1

// Read-only counters and machine info
`define CYCLE_REGNO         16'h0C00
`define INSTRET_REGNO       16'h0C02
`define MVENDORID_REGNO     16'h0F11
`define MCONFIGPTR_REGNO    16'h0F15

// Integer and floating-point register files
`define X0_REGNO            16'h1000
`define X15_REGNO           16'h100F
`define X16_REGNO           16'h1010
`define X31_REGNO           16'h101F
`define FP0_REGNO           16'h1020
`define FP31_REGNO          16'h103F

// Memory-stage debug scan chain fields, in chain order
`define TRAPM_REGNO         16'hC000
`define PCM_REGNO           16'hC001
`define INSTRM_REGNO        16'hC002
`define MEMRWM_REGNO        16'hC003
`define INSTRVALIDM_REGNO   16'hC004
`define WRITEDATAM_REGNO    16'hC005
`define IEUADRM_REGNO       16'hC006
`define READDATAM_REGNO     16'hC007

`endif

/* hw/debugPkg.sv */
// Shared types for the debug abstract register access path
`default_nettype none

package debugPkg;

  // Width of every data and mask word, equal to LLEN
  localparam int MAXLEN = 64;

  typedef logic [15:0]       regNoT;
  typedef logic [2:0]        aarSizeT;
  typedef logic [9:0]        scanLenT;
  typedef logic [11:0]       regAddrT;
  typedef logic [MAXLEN-1:0] regWordT;

  ////////////////////////////////////////////////////////////////////////////
  // Command and decode records
  ////////////////////////////////////////////////////////////////////////////

  // One access-register command as issued by the debugger
  typedef struct packed {
    regNoT   regNo;
    aarSizeT aarSize;
    logic    transfer;
    logic    write;
  } debugCmdT;

  // Decoder result for one register number
  typedef struct packed {
    logic    gpReg;
    logic    fpReg;
    logic    csReg;
    logic    invalid;
    logic    readOnly;
    scanLenT scanChainLen;
    scanLenT shiftCount;
    regAddrT regAddr;
    regWordT fieldMask;
  } regInfoT;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Abstract command error codes
  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errBusy         = 3'd1,
    errNotSupported = 3'd2,
    errException    = 3'd3
  } cmdErrT;

  typedef enum logic [1:0] {
    idle,
    shift,
    finish
  } seqStateT;

endpackage

`default_nettype wire

/* hw/regDecoder.sv */
// Register decoder: maps a register number to class, validity, shift count and field mask
`default_nettype none

module regDecoder import debugPkg::*; #(
  parameter int XLEN            = 64,
  parameter int FLEN            = 64,
  parameter bit ZICSR_SUPPORTED = 1'b1,
  parameter bit E_SUPPORTED     = 1'b0,
  parameter bit FP_SUPPORTED    = 1'b1,
  parameter bit A_SUPPORTED     = 1'b1,
  parameter bit BPRED_SUPPORTED = 1'b0
) (
  input  regNoT   regNo,
  output regInfoT info
);
  `include "debugRegNo.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Scan chain layout
  ////////////////////////////////////////////////////////////////////////////

  // Field lengths, zero where the field is absent from the chain
  localparam int trapmLen      = ZICSR_SUPPORTED ? 1 : 0;
  localparam int pcmLen        = (ZICSR_SUPPORTED | BPRED_SUPPORTED) ? XLEN : 0;
  localparam int instrmLen     = (ZICSR_SUPPORTED | A_SUPPORTED) ? 32 : 0;
  localparam int memrwmLen     = 2;
  localparam int instrValidLen = 1;
  localparam int writeDataLen  = XLEN;
  localparam int ieuAdrLen     = XLEN;
  localparam int readDataLen   = MAXLEN;
  localparam int chainLen      = MAXLEN - 1 + trapmLen + pcmLen + instrmLen + memrwmLen
                                 + instrValidLen + writeDataLen + ieuAdrLen + readDataLen;

  // Running end offset of each field
  localparam int trapmIdx      = trapmLen;
  localparam int pcmIdx        = trapmIdx + pcmLen;
  localparam int instrmIdx     = pcmIdx + instrmLen;
  localparam int memrwmIdx     = instrmIdx + memrwmLen;
  localparam int instrValidIdx = memrwmIdx + instrValidLen;
  localparam int writeDataIdx  = instrValidIdx + writeDataLen;
  localparam int ieuAdrIdx     = writeDataIdx + ieuAdrLen;
  localparam int readDataIdx   = ieuAdrIdx + readDataLen;

  localparam scanLenT xlenShift = scanLenT'(XLEN - 1);
  localparam scanLenT flenShift = (FLEN > 0) ? scanLenT'(FLEN - 1) : '0;

  localparam regWordT xlenMask = {MAXLEN{1'b1}} >> (MAXLEN - XLEN);
  localparam regWordT flenMask = {MAXLEN{1'b1}} >> (MAXLEN - FLEN);

  assign info.regAddr = regNo[11:0];
  assign info.scanChainLen = (info.csReg | info.gpReg) ? scanLenT'(XLEN) :
                             info.fpReg ? scanLenT'(FLEN) : scanLenT'(chainLen);

  // Class, validity and shift count
  always_comb begin
    info.gpReg      = 1'b0;
    info.fpReg      = 1'b0;
    info.csReg      = 1'b0;
    info.invalid    = 1'b0;
    info.readOnly   = 1'b0;
    info.shiftCount = xlenShift;
    case (regNo) inside
      [`DCSR_REGNO:`DPC_REGNO]: begin
        info.csReg = 1'b1;
      end
      [`FFLAGS_REGNO:`FCSR_REGNO]: begin
        info.csReg   = 1'b1;
        info.invalid = ~(ZICSR_SUPPORTED & FP_SUPPORTED);
      end
      [`SSTATUS_REGNO:`SCOUNTEREN_REGNO],
      [`SSCRATCH_REGNO:`SIP_REGNO],
      `SATP_REGNO,
      [`MSTATUS_REGNO:`MCOUNTEREN_REGNO],
      [`MSCRATCH_REGNO:`MIP_REGNO]: begin
        info.csReg   = 1'b1;
        info.invalid = ~ZICSR_SUPPORTED;
      end
      // Counters and machine info are read only
      [`CYCLE_REGNO:`INSTRET_REGNO],
      [`MVENDORID_REGNO:`MCONFIGPTR_REGNO]: begin
        info.csReg    = 1'b1;
        info.invalid  = ~ZICSR_SUPPORTED;
        info.readOnly = 1'b1;
      end
      [`X0_REGNO:`X15_REGNO]: begin
        info.gpReg = 1'b1;
      end
      // Upper half of the register file is absent on RV32E
      [`X16_REGNO:`X31_REGNO]: begin
        info.gpReg   = 1'b1;
        info.invalid = E_SUPPORTED;
      end
      [`FP0_REGNO:`FP31_REGNO]: begin
        info.fpReg      = 1'b1;
        info.invalid    = ~FP_SUPPORTED;
        info.shiftCount = flenShift;
      end
      `TRAPM_REGNO: begin
        info.shiftCount = scanLenT'(chainLen - trapmIdx);
        info.invalid    = ~ZICSR_SUPPORTED;
        info.readOnly   = 1'b1;
      end
      `PCM_REGNO: begin
        info.shiftCount = scanLenT'(chainLen - pcmIdx);
        info.invalid    = ~(ZICSR_SUPPORTED | BPRED_SUPPORTED);
      end
      `INSTRM_REGNO: begin
        info.shiftCount = scanLenT'(chainLen - instrmIdx);
        info.invalid    = ~(ZICSR_SUPPORTED | A_SUPPORTED);
      end
      `MEMRWM_REGNO:      info.shiftCount = scanLenT'(chainLen - memrwmIdx);
      `INSTRVALIDM_REGNO: info.shiftCount = scanLenT'(chainLen - instrValidIdx);
      `WRITEDATAM_REGNO:  info.shiftCount = scanLenT'(chainLen - writeDataIdx);
      `IEUADRM_REGNO:     info.shiftCount = scanLenT'(chainLen - ieuAdrIdx);
      `READDATAM_REGNO: begin
        info.shiftCount = scanLenT'(chainLen - readDataIdx);
        info.readOnly   = 1'b1;
      end
      default: begin
        info.shiftCount = '0;
        info.invalid    = 1'b1;
      end
    endcase
  end

  // Valid bits of the addressed field
  always_comb begin
    case (regNo) inside
      `TRAPM_REGNO,
      `INSTRVALIDM_REGNO:       info.fieldMask = regWordT'(1'b1);
      `INSTRM_REGNO:            info.fieldMask = regWordT'(32'hFFFF_FFFF);
      `MEMRWM_REGNO:            info.fieldMask = regWordT'(2'b11);
      `READDATAM_REGNO:         info.fieldMask = {MAXLEN{1'b1}};
      [`FP0_REGNO:`FP31_REGNO]: info.fieldMask = flenMask;
      default:                  info.fieldMask = xlenMask;
    endcase
  end

endmodule

`default_nettype wire

/* hw/sizeChecker.sv */
// Access size checker: validates aarSize against the configured widths and builds the size mask
`default_nettype none

module sizeChecker import debugPkg::*; #(
  parameter int XLEN = 64,
  parameter int FLEN = 64
) (
  input  debugCmdT cmd,
  output logic     sizeBad,
  output regWordT  sizeMask
);

  // Largest size code understood by this debug module
  localparam aarSizeT size64 = 3'd3;

  // A 64-bit access needs at least one 64-bit register file
  localparam bit has64 = (XLEN == 64) || (FLEN == 64);

  logic sizeTooLarge;
  logic wide64;
  logic noWide;

  ////////////////////////////////////////////////////////////////////////////
  // Size legality
  ////////////////////////////////////////////////////////////////////////////

  // 128-bit and larger codes are never supported
  assign sizeTooLarge = cmd.aarSize > size64;
  assign wide64 = cmd.aarSize == size64;
  assign noWide = wide64 & ~has64;

  // Size only matters when the command moves data
  assign sizeBad = cmd.transfer & (sizeTooLarge | noWide);

  ////////////////////////////////////////////////////////////////////////////
  // Size mask
  ////////////////////////////////////////////////////////////////////////////

  // Low word always passes, the upper word only for a 64-bit access
  always_comb begin
    sizeMask = '0;
    sizeMask[31:0] = '1;
    if (wide64) begin
      sizeMask[MAXLEN-1:32] = '1;
    end
  end

endmodule

`default_nettype wire

/* hw/accessSequencer.sv */
// Access sequencer: raises command errors and runs the scan shift for one abstract command
`default_nettype none

module accessSequencer import debugPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     cmdValid,
  input  debugCmdT cmd,
  input  regInfoT  info,
  input  logic     sizeBad,
  input  regWordT  sizeMask,
  input  regWordT  writeData,
  input  logic     scanIn,
  output logic     busy,
  output logic     cmdDone,
  output cmdErrT   cmdErr,
  output regWordT  readData,
  output logic     scanEn,
  output logic     scanWrite,
  output logic     scanOut
);

  seqStateT state;
  seqStateT stateNext;

  // Command context held for the whole shift
  debugCmdT cmdQ;
  regInfoT  infoQ;
  regWordT  sizeMaskQ;

  scanLenT  count;
  regWordT  capShift;
  regWordT  capNext;
  regWordT  wrShift;
  regWordT  effMask;
  logic [6:0] fieldLen;
  logic     accept;
  logic     cmdBad;
  logic     lastShift;

  function automatic logic [6:0] countOnes(regWordT word);
    logic [6:0] ones;
    ones = '0;
    for (int i = 0; i < MAXLEN; i++) begin
      ones = ones + 7'(word[i]);
    end
    return ones;
  endfunction

  assign accept = cmdValid & (state == idle);
  assign cmdBad = cmd.transfer & (info.invalid | sizeBad | (cmd.write & info.readOnly));

  assign effMask  = infoQ.fieldMask & sizeMaskQ;
  assign fieldLen = countOnes(effMask);
  assign lastShift = (state == shift) && (count == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    stateNext = state;
    case (state)
      idle: begin
        if (accept) begin
          stateNext = (cmd.transfer & ~cmdBad) ? shift : finish;
        end
      end
      shift: begin
        if (count == '0) begin
          stateNext = finish;
        end
      end
      default: stateNext = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state    <= idle;
      count    <= '0;
      cmdErr   <= errNone;
      readData <= '0;
    end else begin
      state <= stateNext;
      if (accept) begin
        count    <= info.shiftCount;
        cmdErr   <= cmdBad ? errNotSupported : errNone;
        readData <= '0;
      end else if (state == shift) begin
        count <= count - 1'b1;
      end
      // Newest bit sits at the top, so drop the unused low part and mask
      if (lastShift) begin
        readData <= (capNext >> (MAXLEN - fieldLen)) & effMask;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Scan data path
  ////////////////////////////////////////////////////////////////////////////

  assign capNext = {scanIn, capShift[MAXLEN-1:1]};

  always_ff @(posedge clk) begin
    if (accept) begin
      cmdQ      <= cmd;
      infoQ     <= info;
      sizeMaskQ <= sizeMask;
      wrShift   <= writeData & info.fieldMask & sizeMask;
    end else if (scanWrite) begin
      wrShift <= wrShift >> 1;
    end
    if (scanEn) begin
      capShift <= capNext;
    end
  end

  assign busy    = state == shift;
  assign scanEn  = state == shift;
  assign cmdDone = state == finish;

  // Field occupies the final fieldLen shift cycles
  assign scanWrite = scanEn & cmdQ.write & (count < {3'b000, fieldLen});
  assign scanOut   = scanWrite & wrShift[0];

endmodule

`default_nettype wire

/* hw/debugRegAccess.sv */
// Abstract register access top level: decoder, size checker and access sequencer
`default_nettype none

module debugRegAccess import debugPkg::*; #(
  parameter int XLEN            = 64,
  parameter int FLEN            = 64,
  parameter bit ZICSR_SUPPORTED = 1'b1,
  parameter bit E_SUPPORTED     = 1'b0,
  parameter bit FP_SUPPORTED    = 1'b1,
  parameter bit A_SUPPORTED     = 1'b1,
  parameter bit BPRED_SUPPORTED = 1'b0
) (
  input  logic       clk,
  input  logic       rstN,
  input  logic       cmdValid,
  input  debugCmdT   cmd,
  input  regWordT    writeData,
  input  logic       scanIn,
  output logic       busy,
  output logic       cmdDone,
  output cmdErrT     cmdErr,
  output regWordT    readData,
  output regAddrT    regAddr,
  // {csReg, fpReg, gpReg}
  output logic [2:0] regClass,
  output logic       scanEn,
  output logic       scanOut,
  output logic       scanWrite
);

  regInfoT info;
  logic    sizeBad;
  regWordT sizeMask;

  assign regAddr  = info.regAddr;
  assign regClass = {info.csReg, info.fpReg, info.gpReg};

  regDecoder #(
    .XLEN(XLEN), .FLEN(FLEN), .ZICSR_SUPPORTED(ZICSR_SUPPORTED), .E_SUPPORTED(E_SUPPORTED),
    .FP_SUPPORTED(FP_SUPPORTED), .A_SUPPORTED(A_SUPPORTED), .BPRED_SUPPORTED(BPRED_SUPPORTED)
  ) decoder (.regNo(cmd.regNo), .info(info));

  sizeChecker #(.XLEN(XLEN), .FLEN(FLEN)) sizeCheck (
    .cmd(cmd), .sizeBad(sizeBad), .sizeMask(sizeMask)
  );

  accessSequencer sequencer (
    .clk(clk), .rstN(rstN), .cmdValid(cmdValid), .cmd(cmd), .info(info),
    .sizeBad(sizeBad), .sizeMask(sizeMask), .writeData(writeData), .scanIn(scanIn),
    .busy(busy), .cmdDone(cmdDone), .cmdErr(cmdErr), .readData(readData),
    .scanEn(scanEn), .scanWrite(scanWrite), .scanOut(scanOut)
  );

endmodule

`default_nettype wire

/* bench/debugRegAccess_assert.sv */
// Protocol checks bound into the access sequencer: done pulse and scan strobes
`default_nettype none

module seqProtocolAssert (
  input logic clk,
  input logic rstN,
  input logic cmdValid,
  input logic cmdDone,
  input logic scanEn,
  input logic scanWrite
);

  // Failure tally, read by the testbench at the end of the run
  int failCount = 0;

  // Completion lasts exactly one cycle
  donePulse: assert property (@(posedge clk) disable iff (!rstN) cmdDone |=> !cmdDone)
    else begin
      $error("cmdDone stayed high for more than one cycle");
      failCount++;
    end

  // A shift run only starts right after a command strobe
  idleQuiet: assert property (@(posedge clk) disable iff (!rstN)
    $rose(scanEn) |-> $past(cmdValid))
    else begin
      $error("scanEn started without an accepted command");
      failCount++;
    end

  // The write window sits inside the shift and runs to its end
  writeInShift: assert property (@(posedge clk) disable iff (!rstN)
    scanWrite |-> scanEn ##1 (scanWrite || cmdDone))
    else begin
      $error("scanWrite outside the tail of the shift");
      failCount++;
    end

endmodule

bind accessSequencer seqProtocolAssert protocolCheck (
  .clk(clk), .rstN(rstN), .cmdValid(cmdValid), .cmdDone(cmdDone), .scanEn(scanEn),
  .scanWrite(scanWrite)
);

`default_nettype wire

/* bench/debugRegAccessTb.sv */
// Testbench for the abstract register access path with a serial scan-chain model
`default_nettype none
`include "debugRegNo.svh"

module debugRegAccessTb import debugPkg::*; ();

  localparam int      timeoutCycles = 1000;
  localparam regWordT fullMask      = '1;
  localparam regWordT low32Mask     = 64'h0000_0000_FFFF_FFFF;

  typedef struct packed {
    debugCmdT cmd;
    regWordT  wdata;
    cmdErrT   expErr;
    scanLenT  expCycles;
    regWordT  expMask;
    logic     checkData;
  } testRowT;

  logic       clk = 1'b0;
  logic       rstN;
  logic       cmdValid;
  debugCmdT   cmd;
  regWordT    writeData;
  logic       scanIn = 1'b0;
  logic       busy;
  logic       cmdDone;
  cmdErrT     cmdErr;
  regWordT    readData;
  regAddrT    regAddr;
  logic [2:0] regClass;
  logic       scanEn;
  logic       scanOut;
  logic       scanWrite;

  testRowT    rows[$];
  string      rowNames[$];
  logic       inBits[$];
  logic       outBits[$];
  int         enCycles;
  int         doneCount;
  int         errors;
  bit         timedOut;
  logic [31:0] rnd;

  debugRegAccess #(.XLEN(64), .FLEN(64), .E_SUPPORTED(1'b1)) DUT (
    .clk(clk), .rstN(rstN), .cmdValid(cmdValid), .cmd(cmd), .writeData(writeData),
    .scanIn(scanIn), .busy(busy), .cmdDone(cmdDone), .cmdErr(cmdErr), .readData(readData),
    .regAddr(regAddr), .regClass(regClass), .scanEn(scanEn), .scanOut(scanOut),
    .scanWrite(scanWrite)
  );

  always #2 clk = ~clk;

  // Scan chain model: random serial source, records what the DUT shifts
  initial begin
    void'($urandom(34));
    forever begin
      @(posedge clk);
      if (scanEn) begin
        inBits.push_back(scanIn);
        enCycles++;
      end
      if (scanWrite) begin
        outBits.push_back(scanOut);
      end
      if (cmdDone) begin
        doneCount++;
      end
      rnd = $urandom();
      scanIn <= rnd[0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks and expected values
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkErr(input string name, input cmdErrT got, input cmdErrT exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s = %s, expected %s", $time, name, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic checkWord(input string name, input regWordT got, input regWordT exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkCount(input string name, input scanLenT got, input scanLenT exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkAddr(input string name, input regAddrT got, input regAddrT exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkClass(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic int onesIn(regWordT mask);
    int n;
    n = 0;
    for (int i = 0; i < MAXLEN; i++) begin
      n += int'(mask[i]);
    end
    return n;
  endfunction

  // Last L sampled bits, earliest one at bit 0
  function automatic regWordT expectedRead(regWordT mask);
    int len;
    int n;
    regWordT word;
    len = onesIn(mask);
    n = inBits.size();
    word = '0;
    for (int i = 0; i < len; i++) begin
      if (n - len + i >= 0) begin
        word[i] = inBits[n - len + i];
      end
    end
    return word & mask;
  endfunction

  // Class bits {csr, fpr, gpr} by the debug register number map
  function automatic logic [2:0] expectedClass(regNoT regNo);
    if (regNo inside {[`X0_REGNO:`X31_REGNO]}) begin
      return 3'b001;
    end else if (regNo inside {[`FP0_REGNO:`FP31_REGNO]}) begin
      return 3'b010;
    end else if (regNo < `X0_REGNO) begin
      return 3'b100;
    end
    return 3'b000;
  endfunction

  function automatic regWordT collectedWrite();
    regWordT word;
    word = '0;
    for (int i = 0; i < outBits.size() && i < MAXLEN; i++) begin
      word[i] = outBits[i];
    end
    return word;
  endfunction

  function automatic debugCmdT makeCmd(regNoT regNo, aarSizeT size, logic transfer,
                                       logic write);
    debugCmdT c;
    c.regNo = regNo;
    c.aarSize = size;
    c.transfer = transfer;
    c.write = write;
    return c;
  endfunction

  task automatic addRow(input string name, input debugCmdT c, input regWordT wdata,
                        input cmdErrT expErr, input scanLenT expCycles, input regWordT expMask);
    testRowT row;
    row.cmd = c;
    row.wdata = wdata;
    row.expErr = expErr;
    row.expCycles = expCycles;
    row.expMask = expMask;
    row.checkData = c.transfer && (expErr == errNone);
    rows.push_back(row);
    rowNames.push_back(name);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Command table
  ////////////////////////////////////////////////////////////////////////////

  // XLEN 64 chain: TRAPM 1, PCM 64, INSTRM 32, MEMRWM 2, INSTRVALIDM 1,
  // WRITEDATAM 64, IEUADRM 64, READDATAM 64, plus 63 bits of tail padding
  task automatic buildTable();
    addRow("read x5 64b", makeCmd(`X0_REGNO + 16'd5, 3'd3, 1, 0), '0, errNone, 64, fullMask);
    addRow("read mstatus", makeCmd(`MSTATUS_REGNO, 3'd3, 1, 0), '0, errNone, 64, fullMask);
    addRow("read x3 32b", makeCmd(`X0_REGNO + 16'd3, 3'd2, 1, 0), '0, errNone, 64, low32Mask);
    addRow("read f2", makeCmd(`FP0_REGNO + 16'd2, 3'd3, 1, 0), '0, errNone, 64, fullMask);
    addRow("read TRAPM", makeCmd(`TRAPM_REGNO, 3'd2, 1, 0), '0, errNone, 355, 64'h1);
    addRow("read INSTRM", makeCmd(`INSTRM_REGNO, 3'd2, 1, 0), '0, errNone, 259, low32Mask);
    addRow("read MEMRWM", makeCmd(`MEMRWM_REGNO, 3'd3, 1, 0), '0, errNone, 257, 64'h3);
    addRow("read READDATAM", makeCmd(`READDATAM_REGNO, 3'd3, 1, 0), '0, errNone, 64, fullMask);
    addRow("read READDATAM 32b", makeCmd(`READDATAM_REGNO, 3'd2, 1, 0), '0, errNone, 64,
           low32Mask);
    addRow("write x7", makeCmd(`X0_REGNO + 16'd7, 3'd3, 1, 1), 64'hA5C3_0F1E_7B2D_9684,
           errNone, 64, fullMask);
    addRow("write dpc 32b", makeCmd(`DPC_REGNO, 3'd2, 1, 1), 64'h1357_9BDF_2468_ACE0,
           errNone, 64, low32Mask);
    addRow("write MEMRWM", makeCmd(`MEMRWM_REGNO, 3'd3, 1, 1), 64'hFFFF_0000_FFFF_0002,
           errNone, 257, 64'h3);
    addRow("unknown regNo", makeCmd(16'h5000, 3'd3, 1, 0), '0, errNotSupported, 0, '0);
    addRow("x20 on RV E", makeCmd(`X0_REGNO + 16'd20, 3'd3, 1, 0), '0, errNotSupported, 0, '0);
    addRow("size code 4", makeCmd(`X0_REGNO + 16'd3, 3'd4, 1, 0), '0, errNotSupported, 0, '0);
    addRow("write READDATAM", makeCmd(`READDATAM_REGNO, 3'd3, 1, 1), 64'h55, errNotSupported,
           0, '0);
    addRow("no transfer", makeCmd(`X0_REGNO + 16'd5, 3'd3, 0, 0), '0, errNone, 0, '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Command sequencing
  ////////////////////////////////////////////////////////////////////////////

  // Ends on the edge where the DUT accepts the command
  task automatic issue(input debugCmdT c, input regWordT w);
    @(posedge clk);
    inBits.delete();
    outBits.delete();
    enCycles = 0;
    doneCount = 0;
    cmdValid <= 1'b1;
    cmd <= c;
    writeData <= w;
    @(posedge clk);
    // Decoder outputs follow the live register number
    checkAddr("regAddr", regAddr, c.regNo[11:0]);
    checkClass("regClass", regClass, expectedClass(c.regNo));
    cmdValid <= 1'b0;
    // Changes after acceptance must not reach the running command
    cmd <= '1;
    writeData <= ~w;
  endtask

  task automatic waitDone(output int latency, output bit seen);
    latency = 0;
    seen = 1'b0;
    while (!seen && latency < timeoutCycles) begin
      @(posedge clk);
      latency++;
      if (cmdDone) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      $display("Timeout: cmdDone did not arrive within %0d cycles", timeoutCycles);
      errors++;
      timedOut = 1'b1;
    end
  endtask

  task automatic runRow(input int idx);
    testRowT row;
    int errorsAtStart;
    int latency;
    bit seen;
    row = rows[idx];
    errorsAtStart = errors;
    issue(row.cmd, row.wdata);
    waitDone(latency, seen);
    if (seen) begin
      checkErr("cmdErr", cmdErr, row.expErr);
      checkBit("busy", busy, 1'b0);
      checkCount("done latency", scanLenT'(latency), row.expCycles + 1'b1);
      checkCount("scanEn cycles", scanLenT'(enCycles), row.expCycles);
      if (row.checkData) begin
        checkWord("readData", readData, expectedRead(row.expMask));
      end
      if (row.checkData && row.cmd.write) begin
        checkCount("scanWrite cycles", scanLenT'(outBits.size()), scanLenT'(onesIn(row.expMask)));
        checkWord("scanOut", collectedWrite(), row.wdata & row.expMask);
      end else begin
        checkCount("scanWrite cycles", scanLenT'(outBits.size()), '0);
      end
    end
    $display("[%0d] %s: %s", idx, rowNames[idx], (errors == errorsAtStart) ? "ok" : "mismatch");
  endtask

  // Second strobe lands mid-shift and must vanish
  task automatic runBackPressure();
    int errorsAtStart;
    int latency;
    bit seen;
    errorsAtStart = errors;
    issue(makeCmd(`X0_REGNO + 16'd9, 3'd3, 1, 0), '0);
    repeat (2) @(posedge clk);
    checkBit("busy", busy, 1'b1);
    cmdValid <= 1'b1;
    cmd <= makeCmd(`READDATAM_REGNO, 3'd3, 1, 1);
    @(posedge clk);
    cmdValid <= 1'b0;
    waitDone(latency, seen);
    if (seen) begin
      checkErr("cmdErr", cmdErr, errNone);
      checkCount("done latency", scanLenT'(latency + 3), 65);
      checkCount("scanEn cycles", scanLenT'(enCycles), 64);
      checkWord("readData", readData, expectedRead(fullMask));
      repeat (4) @(posedge clk);
      checkCount("cmdDone pulses", scanLenT'(doneCount), 1);
    end
    $display("[%0d] back-pressure: %s", rows.size(), (errors == errorsAtStart) ? "ok" : "mismatch");
  endtask

  initial begin
    rstN = 1'b0;
    cmdValid = 1'b0;
    cmd = '0;
    writeData = '0;
    errors = 0;
    timedOut = 1'b0;
    buildTable();
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    checkBit("busy", busy, 1'b0);
    checkBit("cmdDone", cmdDone, 1'b0);
    checkBit("scanEn", scanEn, 1'b0);
    checkBit("scanWrite", scanWrite, 1'b0);
    checkBit("scanOut", scanOut, 1'b0);
    checkErr("cmdErr", cmdErr, errNone);
    checkWord("readData", readData, '0);
    for (int i = 0; i < rows.size(); i++) begin
      if (!timedOut) begin
        runRow(i);
      end
    end
    if (!timedOut) begin
      runBackPressure();
    end
    errors += DUT.sequencer.protocolCheck.failCount;
    $display("Summary: %0d tests, %0d errors", rows.size() + 1, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* debugRegAccess.f */
+incdir+include
hw/debugPkg.sv
hw/regDecoder.sv
hw/sizeChecker.sv
hw/accessSequencer.sv
hw/debugRegAccess.sv
bench/debugRegAccess_assert.sv
bench/debugRegAccessTb.sv
